//--- test/frontend_testdata.txt
# in: inst0 inst1 v0 v1 stall redirect redirect_pc jalr_done, then expected after the next edge:
# fetch_pc wait_for_jalr id_valid0 id_valid1 id_pred_taken id_pred_slot id_pc0 (hex, inst 0 = filler)
0 0 1 1 0 0 0 0 8 0 1 1 0 0 0
0 0 1 1 0 0 0 0 10 0 1 1 0 0 8
00000863 0 1 1 0 0 0 0 18 0 1 1 0 0 10
fe000ce3 0 1 1 0 0 0 0 10 0 1 0 1 0 18
0 0200006f 1 1 0 0 0 0 34 0 1 1 1 1 10
0 0 1 1 1 0 0 0 34 0 1 1 1 1 10
0 0 1 1 1 0 0 0 34 0 1 1 1 1 10
0200006f 0 1 1 0 0 0 0 54 0 1 0 1 0 34
0 00008067 1 1 0 0 0 0 5c 1 1 1 0 0 54
0 0 1 1 0 0 0 0 5c 1 0 0 0 0 0
0 0 1 1 0 0 0 0 5c 1 0 0 0 0 0
0 0 1 1 0 1 100 1 100 0 0 0 0 0 0
0 0 1 1 0 0 0 0 108 0 1 1 0 0 100
fe000ce3 0 1 1 0 1 200 0 200 0 0 0 0 0 0
0 0 1 1 1 1 300 0 300 0 0 0 0 0 0
0 0 0 1 0 0 0 0 308 0 0 1 0 0 300
0 fe000ce3 1 1 0 0 0 0 304 0 1 1 1 1 308
00008067 0 1 1 0 0 0 0 30c 1 1 1 0 0 304
0 0 1 1 1 0 0 0 30c 1 1 1 0 0 304
0 0 1 1 0 1 40 1 40 0 0 0 0 0 0
0 0 1 1 0 0 0 0 48 0 1 1 0 0 40
0200006f 0 0 1 0 0 0 0 50 0 0 1 0 0 48
0 0 1 1 0 0 0 0 58 0 1 1 0 0 50

//--- sources.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/frontend_pkg.sv
hdl/static_branch_predictor.sv
hdl/fetch_ctrl.sv
hdl/pc_counter.sv
hdl/fetch_slot_reg.sv
hdl/frontend_top.sv
test/frontend_checker.sv
test/frontend_monitor.sv
test/tb_frontend.sv

//--- Makefile
SRCS := $(wildcard hdl/*.sv test/*.sv include/*.svh)

.PHONY: run clean

# rebuilt only when a source or the file list changes
obj_dir/Vtb_frontend: sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module tb_frontend -o Vtb_frontend

run: obj_dir/Vtb_frontend
	./obj_dir/Vtb_frontend | tee sim.log
	grep -q -- ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_frontend.sv
// tb_frontend: testbench top for the fetch front end
// clock, reset, test data loader, stimulus driver, watchdog, verdict

`timescale 1ns/10ps
`default_nettype none

module tb_frontend;

    localparam int MAX_LINES = 64;
    localparam int N_FIELDS  = 15;   // 8 input columns, 7 expected columns

    logic                clk;
    logic                rst_n;
    rv_isa_pkg::inst_t   inst0;
    rv_isa_pkg::inst_t   inst1;
    logic                inst0_valid;
    logic                inst1_valid;
    logic                stall;
    logic                redirect;
    frontend_pkg::addr_t redirect_pc;
    logic                jalr_done;

    // dut outputs
    frontend_pkg::addr_t fetch_pc;
    logic                id_valid0, id_valid1;
    frontend_pkg::addr_t id_pc0;
    rv_isa_pkg::inst_t   id_inst0, id_inst1;
    logic                id_pred_taken;
    frontend_pkg::slot_t id_pred_slot;
    logic                id_is_pred_branch;
    logic                wait_for_jalr;

    // expected values handed to the monitor
    logic                exp_valid;
    frontend_pkg::addr_t exp_pc, exp_pc0;
    logic                exp_wait, exp_v0, exp_v1, exp_pt;
    frontend_pkg::slot_t exp_slot;
    rv_isa_pkg::inst_t   exp_inst0, exp_inst1;
    logic                exp_br;

    logic [31:0] td [MAX_LINES][N_FIELDS];  // parsed test data
    rv_isa_pkg::inst_t drv_inst0 [MAX_LINES];  // words actually driven, fillers resolved
    rv_isa_pkg::inst_t drv_inst1 [MAX_LINES];
    rv_isa_pkg::inst_t held_inst0;          // pair decode should be showing
    rv_isa_pkg::inst_t held_inst1;
    int          n_lines;
    int          file_errors;
    logic        load_done;
    int          mismatches;
    int          checks;

    frontend_top dut_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .inst0_i             (inst0),
        .inst1_i             (inst1),
        .inst0_valid_i       (inst0_valid),
        .inst1_valid_i       (inst1_valid),
        .fetch_pc_o          (fetch_pc),
        .stall_i             (stall),
        .redirect_i          (redirect),
        .redirect_pc_i       (redirect_pc),
        .jalr_done_i         (jalr_done),
        .id_valid0_o         (id_valid0),
        .id_valid1_o         (id_valid1),
        .id_pc0_o            (id_pc0),
        .id_inst0_o          (id_inst0),
        .id_inst1_o          (id_inst1),
        .id_pred_taken_o     (id_pred_taken),
        .id_pred_slot_o      (id_pred_slot),
        .id_is_pred_branch_o (id_is_pred_branch),
        .wait_for_jalr_o     (wait_for_jalr)
    );

    frontend_monitor u_mon (
        .clk                 (clk),
        .rst_n               (rst_n),
        .exp_valid_i         (exp_valid),
        .exp_pc_i            (exp_pc),
        .exp_wait_i          (exp_wait),
        .exp_v0_i            (exp_v0),
        .exp_v1_i            (exp_v1),
        .exp_pt_i            (exp_pt),
        .exp_slot_i          (exp_slot),
        .exp_pc0_i           (exp_pc0),
        .exp_inst0_i         (exp_inst0),
        .exp_inst1_i         (exp_inst1),
        .exp_br_i            (exp_br),
        .fetch_pc_i          (fetch_pc),
        .wait_for_jalr_i     (wait_for_jalr),
        .id_valid0_i         (id_valid0),
        .id_valid1_i         (id_valid1),
        .id_pred_taken_i     (id_pred_taken),
        .id_pred_slot_i      (id_pred_slot),
        .id_pc0_i            (id_pc0),
        .id_inst0_i          (id_inst0),
        .id_inst1_i          (id_inst1),
        .id_is_pred_branch_i (id_is_pred_branch),
        .mismatches_o        (mismatches),
        .checks_o            (checks)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // idle OP-IMM word, random fields, never a control opcode
    function automatic rv_isa_pkg::inst_t filler_word();
        logic [31:0] r;
        r      = $urandom();
        r[6:0] = 7'b0010011;
        return r;
    endfunction

    // zero in the data file marks a don't-care slot
    function automatic rv_isa_pkg::inst_t pick_inst(input logic [31:0] w);
        if (w == 32'h0)
            return filler_word();
        return w;
    endfunction

    task automatic apply_line(input int k);
        drv_inst0[k] = pick_inst(td[k][0]);  // kept for the decode side
        drv_inst1[k] = pick_inst(td[k][1]);
        inst0       <= drv_inst0[k];
        inst1       <= drv_inst1[k];
        inst0_valid <= td[k][2][0];
        inst1_valid <= td[k][3][0];
        stall       <= td[k][4][0];
        redirect    <= td[k][5][0];
        redirect_pc <= td[k][6];
        jalr_done   <= td[k][7][0];
    endtask

    // results of line k show one edge after it was applied
    task automatic hand_expected(input int k);
        frontend_pkg::addr_t fetched_at;
        rv_isa_pkg::inst_t   winner;
        if (k == 0)
            fetched_at = frontend_pkg::RESET_PC;
        else
            fetched_at = td[k-1][8];
        // pair reaches decode only if decode then shows its own pc
        if ((td[k][10][0] || td[k][11][0]) && td[k][14] == fetched_at) begin
            held_inst0 = drv_inst0[k];
            held_inst1 = drv_inst1[k];
        end
        winner = td[k][13][0] ? held_inst1 : held_inst0;
        exp_valid <= 1'b1;
        exp_pc    <= td[k][8];
        exp_wait  <= td[k][9][0];
        exp_v0    <= td[k][10][0];
        exp_v1    <= td[k][11][0];
        exp_pt    <= td[k][12][0];
        exp_slot  <= td[k][13][0];
        exp_pc0   <= td[k][14];
        exp_inst0 <= held_inst0;
        exp_inst1 <= held_inst1;
        // conditional branch winner only, jal stays low
        exp_br    <= td[k][12][0] && (winner[6:0] == rv_isa_pkg::OPC_BRANCH);
    endtask

    initial begin : main_seq
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f [N_FIELDS];
        rst_n       = 1'b0;
        inst0       = '0;
        inst1       = '0;
        inst0_valid = 1'b0;
        inst1_valid = 1'b0;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        jalr_done   = 1'b0;
        exp_valid   = 1'b0;
        exp_pc      = '0;
        exp_wait    = 1'b0;
        exp_v0      = 1'b0;
        exp_v1      = 1'b0;
        exp_pt      = 1'b0;
        exp_slot    = '0;
        exp_pc0     = '0;
        exp_inst0   = '0;
        exp_inst1   = '0;
        exp_br      = 1'b0;
        held_inst0  = '0;
        held_inst1  = '0;
        n_lines     = 0;
        file_errors = 0;
        load_done   = 1'b0;
        void'($urandom(82));

        fd = $fopen("test/frontend_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file test/frontend_testdata.txt");
            file_errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                rc = $fgets(line, fd);
                // skip blank and comment lines
                if (rc > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                 f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                    if (rc == N_FIELDS) begin
                        for (int j = 0; j < N_FIELDS; j++)
                            td[n_lines][j] = f[j];
                        n_lines++;
                    end else begin
                        $display("a test data line has %0d fields instead of %0d", rc, N_FIELDS);
                        file_errors++;
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                $display("the test data file holds no test lines");
                file_errors++;
            end
        end
        load_done = 1'b1;

        // reset held over 4 rising edges, released with the first line
        repeat (3) @(posedge clk);
        for (int i = 0; i <= n_lines; i++) begin
            @(posedge clk);
            rst_n <= 1'b1;
            if (i > 0)
                hand_expected(i - 1);
            if (i < n_lines)
                apply_line(i);
        end
        @(negedge clk);
        #1;  // last compare done

        $display("checks %0d, mismatches %0d, file errors %0d", checks, mismatches, file_errors);
        if (mismatches == 0 && file_errors == 0 && n_lines > 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial begin : watchdog
        wait (load_done);
        #(n_lines * 8 + 200);
        $display("watchdog expired before the test sequence finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/frontend_monitor.sv
// frontend_monitor: compares front-end outputs with expected values
// checks reset values once, then every falling edge with an expectation

`timescale 1ns/10ps
`default_nettype none

module frontend_monitor (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      exp_valid_i,   // expectation present this cycle
    input  wire frontend_pkg::addr_t exp_pc_i,
    input  wire                      exp_wait_i,
    input  wire                      exp_v0_i,
    input  wire                      exp_v1_i,
    input  wire                      exp_pt_i,
    input  wire frontend_pkg::slot_t exp_slot_i,
    input  wire frontend_pkg::addr_t exp_pc0_i,
    input  wire rv_isa_pkg::inst_t   exp_inst0_i,
    input  wire rv_isa_pkg::inst_t   exp_inst1_i,
    input  wire                      exp_br_i,      // winner is a conditional branch
    input  wire frontend_pkg::addr_t fetch_pc_i,
    input  wire                      wait_for_jalr_i,
    input  wire                      id_valid0_i,
    input  wire                      id_valid1_i,
    input  wire                      id_pred_taken_i,
    input  wire frontend_pkg::slot_t id_pred_slot_i,
    input  wire frontend_pkg::addr_t id_pc0_i,
    input  wire rv_isa_pkg::inst_t   id_inst0_i,
    input  wire rv_isa_pkg::inst_t   id_inst1_i,
    input  wire                      id_is_pred_branch_i,
    output int                       mismatches_o,
    output int                       checks_o
);

    int   mismatches = 0;
    int   checks     = 0;
    logic reset_checked = 1'b0;

    task automatic compare_field(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            mismatches++;
            $display("error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    always @(negedge clk) begin
        // first cycle out of reset
        if (rst_n && !reset_checked) begin
            reset_checked = 1'b1;
            compare_field("fetch_pc_o", frontend_pkg::RESET_PC, fetch_pc_i);
            compare_field("id_valid0_o", 32'h0, 32'(id_valid0_i));
            compare_field("id_valid1_o", 32'h0, 32'(id_valid1_i));
            compare_field("id_pred_taken_o", 32'h0, 32'(id_pred_taken_i));
            compare_field("wait_for_jalr_o", 32'h0, 32'(wait_for_jalr_i));
        end
        if (exp_valid_i) begin
            compare_field("fetch_pc_o", exp_pc_i, fetch_pc_i);
            compare_field("wait_for_jalr_o", 32'(exp_wait_i), 32'(wait_for_jalr_i));
            compare_field("id_valid0_o", 32'(exp_v0_i), 32'(id_valid0_i));
            compare_field("id_valid1_o", 32'(exp_v1_i), 32'(id_valid1_i));
            compare_field("id_pred_taken_o", 32'(exp_pt_i), 32'(id_pred_taken_i));
            if (exp_pt_i)  // slot only means something when taken
                compare_field("id_pred_slot_o", 32'(exp_slot_i), 32'(id_pred_slot_i));
            if (exp_v0_i)
                compare_field("id_inst0_o", exp_inst0_i, id_inst0_i);
            if (exp_v1_i)
                compare_field("id_inst1_o", exp_inst1_i, id_inst1_i);
            if (exp_v0_i || exp_v1_i) begin  // payload stale behind a bubble
                compare_field("id_pc0_o", exp_pc0_i, id_pc0_i);
                compare_field("id_is_pred_branch_o", 32'(exp_br_i),
                              32'(id_is_pred_branch_i));
            end
        end
    end

    assign mismatches_o = mismatches;
    assign checks_o     = checks;

endmodule

`default_nettype wire

//--- test/frontend_checker.sv
// frontend_checker: concurrent assertions bound into frontend_top
// jalr freeze, slot-1 kill, known outputs after reset

`timescale 1ns/10ps
`default_nettype none

module frontend_checker (
    input wire                      clk,
    input wire                      rst_n,
    input wire                      redirect_i,
    input wire                      wait_for_jalr_i,
    input wire frontend_pkg::addr_t fetch_pc_i,
    input wire                      id_valid0_i,
    input wire                      id_valid1_i,
    input wire                      id_pred_taken_i,
    input wire frontend_pkg::slot_t id_pred_slot_i
);

    // pc frozen while waiting, only execute may move it
    a_jalr_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        (wait_for_jalr_i && !redirect_i) |=> $stable(fetch_pc_i))
        else $error("fetch pc moved during jalr wait without a redirect");

    // slot 1 must be squashed behind a taken slot 0
    a_slot1_killed: assert property (@(posedge clk) disable iff (!rst_n)
        !(id_valid1_i && id_pred_taken_i && (id_pred_slot_i == 1'b0)))
        else $error("younger slot valid behind a taken older slot");

    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({fetch_pc_i, wait_for_jalr_i, id_valid0_i, id_valid1_i, id_pred_taken_i}))
        else $error("front-end outputs unknown after reset");

endmodule

bind frontend_top frontend_checker u_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .redirect_i      (redirect_i),
    .wait_for_jalr_i (wait_for_jalr_o),
    .fetch_pc_i      (fetch_pc_o),
    .id_valid0_i     (id_valid0_o),
    .id_valid1_i     (id_valid1_o),
    .id_pred_taken_i (id_pred_taken_o),
    .id_pred_slot_i  (id_pred_slot_o)
);

`default_nettype wire

//--- hdl/frontend_top.sv
// frontend_top: dual-issue fetch front end
// predictor, fetch FSM, pc counter and decode register

`timescale 1ns/10ps
`default_nettype none

module frontend_top (
    input  wire                      clk,
    input  wire                      rst_n,
    // instruction memory, answers in the same cycle
    input  wire rv_isa_pkg::inst_t   inst0_i,
    input  wire rv_isa_pkg::inst_t   inst1_i,
    input  wire                      inst0_valid_i,
    input  wire                      inst1_valid_i,
    output wire frontend_pkg::addr_t fetch_pc_o,
    // pipeline control
    input  wire                      stall_i,
    input  wire                      redirect_i,
    input  wire frontend_pkg::addr_t redirect_pc_i,
    input  wire                      jalr_done_i,
    // to decode
    output wire                      id_valid0_o,
    output wire                      id_valid1_o,
    output wire frontend_pkg::addr_t id_pc0_o,
    output wire rv_isa_pkg::inst_t   id_inst0_o,
    output wire rv_isa_pkg::inst_t   id_inst1_o,
    output wire                      id_pred_taken_o,
    output wire frontend_pkg::slot_t id_pred_slot_o,
    output wire                      id_is_pred_branch_o,
    output wire                      wait_for_jalr_o
);

    wire                      pred_taken;
    wire frontend_pkg::addr_t pred_target;
    wire frontend_pkg::slot_t pred_slot;
    wire                      is_pred_branch;
    wire                      slot1_kill;
    wire                      jalr_seen;
    wire                      fetch_en;    // one enable for pc and decode register

    static_branch_predictor u_sbp (
        .inst0_i          (inst0_i),
        .inst1_i          (inst1_i),
        .inst0_valid_i    (inst0_valid_i),
        .inst1_valid_i    (inst1_valid_i),
        .pc0_i            (fetch_pc_o),
        .pred_taken_o     (pred_taken),
        .pred_target_o    (pred_target),
        .pred_slot_o      (pred_slot),
        .is_pred_branch_o (is_pred_branch),
        .slot1_kill_o     (slot1_kill),
        .jalr_seen_o      (jalr_seen)
    );

    fetch_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall_i         (stall_i),
        .jalr_seen_i     (jalr_seen),
        .jalr_done_i     (jalr_done_i),
        .fetch_en_o      (fetch_en),
        .wait_for_jalr_o (wait_for_jalr_o)
    );

    pc_counter u_pc (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_en_i    (fetch_en),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fetch_pc_o    (fetch_pc_o)
    );

    fetch_slot_reg u_slot (
        .clk                 (clk),
        .rst_n               (rst_n),
        .fetch_en_i          (fetch_en),
        .stall_i             (stall_i),
        .redirect_i          (redirect_i),
        .inst0_i             (inst0_i),
        .inst1_i             (inst1_i),
        .inst0_valid_i       (inst0_valid_i),
        .inst1_valid_i       (inst1_valid_i),
        .slot1_kill_i        (slot1_kill),
        .pc0_i               (fetch_pc_o),
        .pred_taken_i        (pred_taken),
        .pred_slot_i         (pred_slot),
        .is_pred_branch_i    (is_pred_branch),
        .id_valid0_o         (id_valid0_o),
        .id_valid1_o         (id_valid1_o),
        .id_pc0_o            (id_pc0_o),
        .id_inst0_o          (id_inst0_o),
        .id_inst1_o          (id_inst1_o),
        .id_pred_taken_o     (id_pred_taken_o),
        .id_pred_slot_o      (id_pred_slot_o),
        .id_is_pred_branch_o (id_is_pred_branch_o)
    );

endmodule

`default_nettype wire

//--- hdl/fetch_slot_reg.sv
// fetch_slot_reg: fetch to decode pipeline register
// squashes on redirect, bubble and slot-1 kill, holds under stall

`timescale 1ns/10ps
`default_nettype none

module fetch_slot_reg (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      fetch_en_i,
    input  wire                      stall_i,
    input  wire                      redirect_i,
    input  wire rv_isa_pkg::inst_t   inst0_i,
    input  wire rv_isa_pkg::inst_t   inst1_i,
    input  wire                      inst0_valid_i,
    input  wire                      inst1_valid_i,
    input  wire                      slot1_kill_i,     // slot 0 predicted taken
    input  wire frontend_pkg::addr_t pc0_i,
    input  wire                      pred_taken_i,
    input  wire frontend_pkg::slot_t pred_slot_i,
    input  wire                      is_pred_branch_i,
    output logic                     id_valid0_o,
    output logic                     id_valid1_o,
    output frontend_pkg::addr_t      id_pc0_o,
    output rv_isa_pkg::inst_t        id_inst0_o,
    output rv_isa_pkg::inst_t        id_inst1_o,
    output logic                     id_pred_taken_o,
    output frontend_pkg::slot_t      id_pred_slot_o,
    output logic                     id_is_pred_branch_o
);

    logic bubble;

    // frozen front end but decode is free, so send nothing
    assign bubble = ~fetch_en_i & ~stall_i;

    // valid bits and prediction flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid0_o     <= 1'b0;
            id_valid1_o     <= 1'b0;
            id_pred_taken_o <= 1'b0;
        end else if (redirect_i || bubble) begin
            id_valid0_o     <= 1'b0;  // wrong path or empty cycle
            id_valid1_o     <= 1'b0;
            id_pred_taken_o <= 1'b0;
        end else if (fetch_en_i) begin
            id_valid0_o     <= inst0_valid_i;
            id_valid1_o     <= inst1_valid_i & ~slot1_kill_i;  // younger than a taken slot 0
            id_pred_taken_o <= pred_taken_i;
        end
        // stall holds
    end

    // payload, only meaningful with its valid bit
    always_ff @(posedge clk) begin
        if (fetch_en_i) begin
            id_pc0_o            <= pc0_i;
            id_inst0_o          <= inst0_i;
            id_inst1_o          <= inst1_i;
            id_pred_slot_o      <= pred_slot_i;
            id_is_pred_branch_o <= is_pred_branch_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pc_counter.sv
// pc_counter: fetch program counter
// steps one pair per fetch, loads prediction, redirect overrides all

`timescale 1ns/10ps
`default_nettype none

module pc_counter (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      fetch_en_i,
    input  wire                      pred_taken_i,
    input  wire frontend_pkg::addr_t pred_target_i,
    input  wire                      redirect_i,    // correction from execute
    input  wire frontend_pkg::addr_t redirect_pc_i,
    output frontend_pkg::addr_t      fetch_pc_o
);

    frontend_pkg::addr_t pc_q;
    frontend_pkg::addr_t pc_seq;

    assign pc_seq = pc_q + frontend_pkg::FETCH_STRIDE;  // next pair

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= frontend_pkg::RESET_PC;
        end else if (redirect_i) begin
            // wins over stall and jalr wait
            pc_q <= redirect_pc_i;
        end else if (fetch_en_i) begin
            if (pred_taken_i)
                pc_q <= pred_target_i;  // static prediction
            else
                pc_q <= pc_seq;
        end
        // else hold, stalled or waiting on jalr
    end

    assign fetch_pc_o = pc_q;

endmodule

`default_nettype wire

//--- hdl/fetch_ctrl.sv
// fetch_ctrl: fetch FSM, normal fetch and wait for jalr resolution
// produces the single fetch enable of the front end

`timescale 1ns/10ps
`default_nettype none

module fetch_ctrl (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  stall_i,         // decode full
    input  wire  jalr_seen_i,     // from predictor
    input  wire  jalr_done_i,     // execute resolved the jalr
    output logic fetch_en_o,
    output logic wait_for_jalr_o
);

    frontend_pkg::fetch_state_e state_q;
    frontend_pkg::fetch_state_e state_d;

    // fetch only in ST_FETCH and when decode can take the pair
    assign fetch_en_o      = (state_q == frontend_pkg::ST_FETCH) & ~stall_i;
    assign wait_for_jalr_o = (state_q == frontend_pkg::ST_JALR_WAIT);

    always_comb begin
        state_d = state_q;  // redirect alone leaves the state alone
        case (state_q)
            frontend_pkg::ST_FETCH: begin
                // jalr pair must actually be handed on before freezing
                if (jalr_seen_i && fetch_en_o)
                    state_d = frontend_pkg::ST_JALR_WAIT;
            end
            frontend_pkg::ST_JALR_WAIT: begin
                if (jalr_done_i)
                    state_d = frontend_pkg::ST_FETCH;
            end
            default: state_d = frontend_pkg::ST_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= frontend_pkg::ST_FETCH;
        else
            state_q <= state_d;
    end

endmodule

`default_nettype wire

//--- hdl/static_branch_predictor.sv
// static_branch_predictor: dual-slot static prediction, combinational
// backward branches and jal are taken, older slot wins, one target adder

`timescale 1ns/10ps
`default_nettype none

module static_branch_predictor (
    input  wire rv_isa_pkg::inst_t     inst0_i,        // older instruction
    input  wire rv_isa_pkg::inst_t     inst1_i,        // younger instruction
    input  wire                        inst0_valid_i,
    input  wire                        inst1_valid_i,
    input  wire frontend_pkg::addr_t   pc0_i,          // pc of older slot
    output logic                       pred_taken_o,
    output frontend_pkg::addr_t        pred_target_o,
    output frontend_pkg::slot_t        pred_slot_o,    // winning slot
    output logic                       is_pred_branch_o, // winner is B-type, not jal
    output logic                       slot1_kill_o,   // slot 0 redirects, drop slot 1
    output logic                       jalr_seen_o     // live jalr in the pair
);

    rv_isa_pkg::opcode_t opc0;
    rv_isa_pkg::opcode_t opc1;
    logic                is_br0, is_jal0, is_jalr0;
    logic                is_br1, is_jal1, is_jalr1;
    rv_isa_pkg::imm_t    imm_b0, imm_j0;
    rv_isa_pkg::imm_t    imm_b1, imm_j1;
    logic                act0, act1;        // slot takes part in prediction
    logic                slot1_disable;
    logic                taken0, taken1;
    logic                from_slot1;
    frontend_pkg::addr_t pc1;
    frontend_pkg::addr_t base_pc;
    rv_isa_pkg::imm_t    sel_imm;

    // opcode decode, older slot
    assign opc0     = inst0_i[6:0];
    assign is_br0   = (opc0 == rv_isa_pkg::OPC_BRANCH);
    assign is_jal0  = (opc0 == rv_isa_pkg::OPC_JAL);
    assign is_jalr0 = (opc0 == rv_isa_pkg::OPC_JALR);

    // opcode decode, younger slot
    assign opc1     = inst1_i[6:0];
    assign is_br1   = (opc1 == rv_isa_pkg::OPC_BRANCH);
    assign is_jal1  = (opc1 == rv_isa_pkg::OPC_JAL);
    assign is_jalr1 = (opc1 == rv_isa_pkg::OPC_JALR);

    // B-type offset, bit 0 always zero
    assign imm_b0 = {{20{inst0_i[31]}}, inst0_i[7], inst0_i[30:25], inst0_i[11:8], 1'b0};
    assign imm_b1 = {{20{inst1_i[31]}}, inst1_i[7], inst1_i[30:25], inst1_i[11:8], 1'b0};

    // J-type offset
    assign imm_j0 = {{12{inst0_i[31]}}, inst0_i[19:12], inst0_i[20], inst0_i[30:21], 1'b0};
    assign imm_j1 = {{12{inst1_i[31]}}, inst1_i[19:12], inst1_i[20], inst1_i[30:21], 1'b0};

    assign act0   = inst0_valid_i;
    assign taken0 = act0 & ((is_br0 & imm_b0[31]) | is_jal0);  // negative offset = loop

    // slot 1 is dead behind a taken slot 0, jal included
    assign slot1_disable = taken0;
    assign act1          = inst1_valid_i & ~slot1_disable;
    assign taken1        = act1 & ((is_br1 & imm_b1[31]) | is_jal1);

    // older slot priority
    assign from_slot1   = taken1 & ~taken0;
    assign pred_taken_o = taken0 | taken1;
    assign pred_slot_o  = from_slot1;
    assign slot1_kill_o = taken0;

    // conditional branch only, jal does not count
    assign is_pred_branch_o = taken0 ? is_br0 : (from_slot1 & is_br1);

    // jalr behind a taken slot 0 is never reached
    assign jalr_seen_o = (act0 & is_jalr0) | (act1 & is_jalr1);

    assign pc1 = pc0_i + 'd4;

    // pick base and offset of the winner, then one shared adder
    always_comb begin
        if (from_slot1) begin
            base_pc = pc1;
            sel_imm = is_br1 ? imm_b1 : imm_j1;
        end else begin
            base_pc = pc0_i;  // also the idle choice when nothing is taken
            sel_imm = is_br0 ? imm_b0 : imm_j0;
        end
    end

    assign pred_target_o = base_pc + sel_imm;

endmodule

`default_nettype wire

//--- hdl/frontend_pkg.sv
// front-end package
// address type, reset vector, fetch stride, fetch FSM states, slot index

`default_nettype none

package frontend_pkg;

`include "frontend_defs.svh"

    // byte address of an instruction
    typedef logic [`INST_ADDR_WIDTH-1:0] addr_t;

    localparam addr_t RESET_PC = 32'h0000_0000;  // first fetch after reset

    // two 4-byte instructions per fetch
    localparam addr_t FETCH_STRIDE = 32'd8;

    // fetch FSM
    typedef enum logic [0:0] {
        ST_FETCH     = 1'b0,  // normal pair fetch
        ST_JALR_WAIT = 1'b1   // frozen until execute resolves the jalr
    } fetch_state_e;

    // position inside the fetched pair
    // 0 = older slot at fetch_pc, 1 = younger slot at fetch_pc + 4
    typedef logic [0:0] slot_t;

endpackage

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
// RV32I encoding package
// instruction and immediate types, control-flow major opcodes

`default_nettype none

package rv_isa_pkg;

`include "frontend_defs.svh"

    // raw instruction word as fetched
    typedef logic [`INST_DATA_WIDTH-1:0] inst_t;

    // sign-extended immediate, same width as the datapath
    typedef logic [`INST_DATA_WIDTH-1:0] imm_t;

    localparam int OPC_WIDTH = 7;  // major opcode field inst[6:0]

    typedef logic [OPC_WIDTH-1:0] opcode_t;

    // control-flow opcodes the predictor cares about
    localparam opcode_t OPC_BRANCH = 7'b1100011;  // B-type, beq..bgeu
    localparam opcode_t OPC_JAL    = 7'b1101111;  // J-type
    localparam opcode_t OPC_JALR   = 7'b1100111;  // I-type, register target

endpackage

`default_nettype wire

//--- include/frontend_defs.svh
// width macros shared by the front-end packages
// instruction word and byte address widths

`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// one RV32I instruction word
`define INST_DATA_WIDTH 32
// byte address into instruction memory
`define INST_ADDR_WIDTH 32

`endif
